// ==== dcache.f ====
+incdir+include
verilog/dcache_pkg.sv
verilog/dcache_bus_pkg.sv
verilog/line_xfer_if.sv
verilog/dcache_way_rams.sv
verilog/dcache_meta.sv
verilog/dcache_ctrl.sv
verilog/line_mover.sv
verilog/dcache.sv
test/axi_mem_model.sv
test/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
RTL_TOP   ?= dcache
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
SIM       ?= $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== test/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_OPS = 200;
    localparam int N_REQ = 15 + RAND_OPS; // directed requests plus random ones
    localparam int CYCLES_PER_REQ = 200;
    localparam logic [31:0] SEED = 32'h38db_2a33;

    logic        clk;
    logic        rst;
    logic        mem_en;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [3:0]  mem_wmask;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        stall;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic [7:0]  awlen;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        proto_err;

    logic [31:0] shadow [logic [31:0]]; // words the CPU has stored

    dcache dut (.*);

    axi_mem_model u_mem (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        if (shadow.exists(addr))
            return shadow[addr];
        return addr ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] mask);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    task automatic stop_failed();
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        stop_failed();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        stop_failed();
    endtask

    // runs one CPU request and counts its stall cycles
    task automatic access(input logic wr, input logic [31:0] addr, input logic [3:0] mask,
                          input logic [31:0] data, output logic [31:0] rd, output int stalls);
        stalls = 0;
        @(posedge clk);
        #1;
        mem_en = 1'b1;
        mem_write = wr;
        mem_addr = addr;
        mem_wmask = mask;
        mem_wdata = data;
        @(negedge clk);
        while (stall) begin
            stalls++;
            @(negedge clk);
        end
        rd = mem_rdata;
    endtask

    task automatic load_check(input string name, input logic [31:0] addr, output int stalls);
        logic [31:0] got;
        access(1'b0, addr, 4'h0, 32'h0, got, stalls);
        assert (got == shadow_word(addr))
            else report_mismatch(name, shadow_word(addr), got);
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [3:0] mask,
                              input logic [31:0] data);
        logic [31:0] unused_rd;
        int          stalls;
        access(1'b1, addr, mask, data, unused_rd, stalls);
        shadow[addr] = merge_bytes(shadow_word(addr), data, mask);
    endtask

    task automatic go_idle();
        @(posedge clk);
        #1;
        mem_en = 1'b0;
    endtask

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + CYCLES_PER_REQ * N_REQ));
        report_problem("watchdog expired before all requests completed");
    end

    always @(posedge clk) begin
        if (proto_err)
            report_problem("memory model saw a malformed burst");
    end

    initial begin
        int          stalls;
        logic [31:0] addr;
        clk = 1'b0;
        rst = 1'b1;
        mem_en = 1'b0;
        mem_write = 1'b0;
        mem_addr = '0;
        mem_wmask = '0;
        mem_wdata = '0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (4) begin // bus quiet until the first request
            @(negedge clk);
            assert (!stall && !arvalid && !awvalid && !wvalid && !rready)
                else report_problem("stall or a bus valid is active after reset");
        end

        load_check("cold_load", 32'h0000_0024, stalls);

        addr = 32'h0000_4028;
        store_word(addr, 4'($urandom), $urandom);
        load_check("masked_store", addr, stalls);

        // three tags on set 5 so the third store pushes out a dirty line
        for (int k = 0; k < 3; k++)
            store_word(32'h0001_0054 + 32'(k) * 32'h100, 4'hf, $urandom);
        for (int k = 0; k < 3; k++)
            load_check("dirty_evict", 32'h0001_0054 + 32'(k) * 32'h100, stalls);

        // lines A B C on set 9
        load_check("lru_a", 32'h0002_0090, stalls);
        load_check("lru_b", 32'h0002_0190, stalls);
        load_check("lru_a", 32'h0002_0090, stalls);
        load_check("lru_c", 32'h0002_0290, stalls);
        load_check("lru_hit_a", 32'h0002_0090, stalls);
        assert (stalls == 1)
            else report_mismatch("lru_hit_a stall cycles", 32'd1, 32'(stalls));
        load_check("lru_miss_b", 32'h0002_0190, stalls);
        assert (stalls > 1)
            else report_problem("line B stayed cached although LRU should have evicted it");

        for (int n = 0; n < RAND_OPS; n++) begin
            addr = 32'h0800_0000 | (($urandom % 4) << 8) | (($urandom % 4) << 4)
                 | (($urandom % 4) << 2); // 64 words over 4 tags and 4 sets
            if ($urandom % 2)
                store_word(addr, 4'($urandom), $urandom);
            else
                load_check("random", addr, stalls);
            if ($urandom % 4 == 0)
                go_idle();
        end

        go_idle();
        if (proto_err) begin
            report_problem("memory model flagged a burst error at the end of the run");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== test/axi_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
    input  wire logic        clk,
    input  wire logic [31:0] araddr,
    input  wire logic [7:0]  arlen,
    input  wire logic        arvalid,
    output logic             arready,
    output logic [31:0]      rdata,
    output logic             rlast,
    output logic             rvalid,
    input  wire logic        rready,
    input  wire logic [31:0] awaddr,
    input  wire logic [7:0]  awlen,
    input  wire logic        awvalid,
    output logic             awready,
    input  wire logic [31:0] wdata,
    input  wire logic        wlast,
    input  wire logic        wvalid,
    output logic             wready,
    output logic             bvalid,
    output logic             proto_err
);
    logic [31:0] mem [logic [31:0]]; // only written words live here
    logic [31:0] wbuf [4];
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    int          rbeat;
    int          wbeat;
    logic        rd_active;
    logic        aw_got;
    logic        w_got;
    logic        r_hold;
    logic        commit;

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (mem.exists(addr))
            return mem[addr];
        return addr ^ 32'h5a5a_0000; // untouched word
    endfunction

    task automatic burst_error(input string what, input logic [31:0] addr);
        $display("memory model: malformed %s near address %h", what, addr);
        proto_err = 1'b1;
    endtask

    initial begin
        arready = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        rvalid = 1'b0;
        rlast = 1'b0;
        rdata = '0;
        bvalid = 1'b0;
        proto_err = 1'b0;
        rd_addr = '0;
        wr_addr = '0;
        rd_active = 1'b0;
        aw_got = 1'b0;
        w_got = 1'b0;
        rbeat = 0;
        wbeat = 0;
    end

    always @(posedge clk) begin
        r_hold = rvalid && !rready; // beat not taken yet
        if (rvalid && rready) begin
            rbeat++;
            if (rlast)
                rd_active = 1'b0;
        end
        if (arvalid && arready) begin
            assert (arlen == 8'd3 && araddr[3:0] == 4'h0)
                else burst_error("read burst", araddr);
            rd_addr = araddr;
            rbeat = 0;
            rd_active = 1'b1;
        end
        if (awvalid && awready) begin
            assert (awlen == 8'd3 && awaddr[3:0] == 4'h0)
                else burst_error("write burst", awaddr);
            wr_addr = awaddr;
            aw_got = 1'b1;
        end
        if (wvalid && wready) begin
            assert (wlast == (wbeat == 3))
                else burst_error("wlast placement", wr_addr);
            wbuf[wbeat[1:0]] = wdata;
            wbeat++;
            if (wlast) begin
                w_got = 1'b1;
                wbeat = 0;
            end
        end
        commit = aw_got && w_got; // address and data both in
        if (commit) begin
            for (int k = 0; k < 4; k++)
                mem[wr_addr + 32'(4 * k)] = wbuf[k];
            aw_got = 1'b0;
            w_got = 1'b0;
        end
        #1;
        arready = ($urandom % 4) != 0;
        awready = ($urandom % 4) != 0;
        wready = ($urandom % 3) != 0;
        bvalid = commit; // one-cycle response
        if (!r_hold) begin
            rvalid = rd_active && ($urandom % 3) != 0;
            rdata = word_at(rd_addr + 32'(4 * rbeat));
            rlast = rbeat == 3;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        mem_en,
    input  wire logic                        mem_write,
    input  wire dcache_bus_pkg::mem_addr_t   mem_addr,
    input  wire logic [3:0]                  mem_wmask,
    input  wire logic [31:0]                 mem_wdata,
    output logic [31:0]                      mem_rdata,
    output logic                             stall,
    output dcache_bus_pkg::mem_addr_t        araddr,
    output logic [7:0]                       arlen,
    output logic                             arvalid,
    input  wire logic                        arready,
    input  wire logic [31:0]                 rdata,
    input  wire logic                        rlast,
    input  wire logic                        rvalid,
    output logic                             rready,
    output dcache_bus_pkg::mem_addr_t        awaddr,
    output logic [7:0]                       awlen,
    output logic                             awvalid,
    input  wire logic                        awready,
    output logic [31:0]                      wdata,
    output logic                             wlast,
    output logic                             wvalid,
    input  wire logic                        wready,
    input  wire logic                        bvalid
);
    import dcache_pkg::*;

    line_xfer_if xfer ();

    index_t      rd_index;
    word_off_t   rd_off;
    logic        hit, hit_way;
    logic [31:0] way_rdata [`DCACHE_NR_WAYS];
    logic [`DCACHE_NR_WAYS-1:0] valid_bits;
    logic        victim_way, victim_dirty;
    logic        cpu_we, cpu_way;
    logic [3:0]  cpu_wmask;
    logic [31:0] cpu_wdata;
    logic        meta_touch, meta_dirty_set;
    logic        fill_we, fill_way, fill_tag_we;
    word_off_t   fill_off;
    logic [31:0] fill_data;
    tag_t        fill_tag, victim_tag;
    logic        wb_done, fill_done;

    // mover owns the word offset while a line is moving
    assign rd_off = xfer.busy ? fill_off : mem_addr[`DCACHE_LEN_LINE-1:2];

    dcache_ctrl u_ctrl (
        .clk, .rst, .mem_en, .mem_write, .mem_addr, .mem_wmask, .mem_wdata,
        .mem_rdata, .stall, .hit, .hit_way, .way_rdata, .victim_way, .victim_dirty,
        .rd_index, .cpu_we, .cpu_way, .cpu_wmask, .cpu_wdata,
        .meta_touch, .meta_dirty_set, .xfer(xfer.ctrl)
    );

    dcache_way_rams u_rams (
        .clk, .rd_index, .rd_off, .cmp_tag(xfer.tag), .valid_bits,
        .hit, .hit_way, .way_rdata, .cpu_we, .cpu_way, .cpu_wmask, .cpu_wdata,
        .fill_we, .fill_way, .fill_index(xfer.index), .fill_off, .fill_data,
        .fill_tag_we, .fill_tag, .victim_tag
    );

    dcache_meta u_meta (
        .clk, .rst, .index(rd_index), .touch(meta_touch), .touch_way(cpu_way),
        .dirty_set(meta_dirty_set), .fill_done, .fill_way, .wb_done,
        .valid_bits, .victim_way, .victim_dirty
    );

    line_mover u_mover (
        .clk, .rst, .xfer(xfer.mover), .victim_way,
        .rd_data(way_rdata[fill_way]), .victim_tag,
        .fill_we, .fill_way, .fill_off, .fill_data, .fill_tag_we, .fill_tag,
        .wb_done, .fill_done,
        .araddr, .arlen, .arvalid, .arready, .rdata, .rlast, .rvalid, .rready,
        .awaddr, .awlen, .awvalid, .awready, .wdata, .wlast, .wvalid, .wready,
        .bvalid
    );

endmodule

`default_nettype wire

// ==== verilog/line_mover.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module line_mover (
    input  wire logic                        clk,
    input  wire logic                        rst,
    line_xfer_if.mover                       xfer,
    input  wire logic                        victim_way,
    input  wire logic [31:0]                 rd_data,
    input  wire dcache_pkg::tag_t            victim_tag,
    output logic                             fill_we,
    output logic                             fill_way,
    output dcache_pkg::word_off_t            fill_off,
    output logic [31:0]                      fill_data,
    output logic                             fill_tag_we,
    output dcache_pkg::tag_t                 fill_tag,
    output logic                             wb_done,
    output logic                             fill_done,
    output dcache_bus_pkg::mem_addr_t        araddr,
    output logic [7:0]                       arlen,
    output logic                             arvalid,
    input  wire logic                        arready,
    input  wire logic [31:0]                 rdata,
    input  wire logic                        rlast,
    input  wire logic                        rvalid,
    output logic                             rready,
    output dcache_bus_pkg::mem_addr_t        awaddr,
    output logic [7:0]                       awlen,
    output logic                             awvalid,
    input  wire logic                        awready,
    output logic [31:0]                      wdata,
    output logic                             wlast,
    output logic                             wvalid,
    input  wire logic                        wready,
    input  wire logic                        bvalid
);
    import dcache_pkg::*;
    import dcache_bus_pkg::*;

    typedef enum logic [2:0] {M_IDLE, M_RD, M_W, M_B, M_R, M_DONE} mstate_e;

    mstate_e  mstate;
    xfer_op_e op_q;
    logic [2:0]  cnt;                // read pointer, then refill beat count
    logic [1:0]  wcnt;
    logic [31:0] rbuf [`DCACHE_WORDS_PER_LINE];
    logic        r_beat;

    assign arlen = 8'(`DCACHE_WORDS_PER_LINE - 1);
    assign awlen = 8'(`DCACHE_WORDS_PER_LINE - 1);

    assign r_beat = mstate == M_R && rvalid && rready;
    assign fill_we = r_beat;
    assign fill_data = rdata;
    assign fill_off = word_off_t'(cnt);
    assign fill_tag_we = r_beat && rlast;

    assign xfer.busy = mstate != M_IDLE && mstate != M_DONE;
    assign xfer.done = mstate == M_DONE;
    assign wb_done = xfer.done && op_q == XFER_WRITEBACK;
    assign fill_done = xfer.done && op_q == XFER_REFILL;

    always_ff @(posedge clk) begin
        if (rst) begin
            mstate <= M_IDLE;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            rready <= 1'b0;
        end else begin
            if (arvalid && arready) arvalid <= 1'b0;
            if (awvalid && awready) awvalid <= 1'b0;
            case (mstate)
                M_IDLE: if (xfer.start) begin
                    op_q <= xfer.op;
                    fill_way <= victim_way;
                    cnt <= '0;
                    fill_tag <= xfer.tag;
                    if (xfer.op == XFER_WRITEBACK) begin
                        mstate <= M_RD;
                    end else begin
                        araddr <= {xfer.tag, xfer.index, `DCACHE_LEN_LINE'(0)};
                        arvalid <= 1'b1;
                        rready <= 1'b1;
                        mstate <= M_R;
                    end
                end
                M_RD: begin
                    // data lags the address by one cycle
                    if (cnt != 0) rbuf[cnt[1:0] - 2'd1] <= rd_data;
                    cnt <= cnt + 3'd1;
                    if (cnt == 3'(`DCACHE_WORDS_PER_LINE)) begin
                        awaddr <= {victim_tag, xfer.index, `DCACHE_LEN_LINE'(0)};
                        awvalid <= 1'b1;
                        wdata <= rbuf[0];
                        wlast <= 1'b0;
                        wvalid <= 1'b1;
                        wcnt <= '0;
                        mstate <= M_W;
                    end
                end
                M_W: if (wvalid && wready) begin
                    if (wlast) begin
                        wvalid <= 1'b0;
                        mstate <= M_B;
                    end else begin
                        wcnt <= wcnt + 2'd1;
                        wdata <= rbuf[wcnt + 2'd1];
                        wlast <= wcnt + 2'd1 == 2'(`DCACHE_WORDS_PER_LINE - 1);
                    end
                end
                M_B: if (bvalid) mstate <= M_DONE;
                M_R: if (r_beat) begin
                    cnt <= cnt + 3'd1;
                    if (rlast) begin
                        rready <= 1'b0;
                        mstate <= M_DONE;
                    end
                end
                default: mstate <= M_IDLE; // done pulse lasts one cycle
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_ctrl (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        mem_en,
    input  wire logic                        mem_write,
    input  wire dcache_bus_pkg::mem_addr_t   mem_addr,
    input  wire logic [3:0]                  mem_wmask,
    input  wire logic [31:0]                 mem_wdata,
    output logic [31:0]                      mem_rdata,
    output logic                             stall,
    input  wire logic                        hit,
    input  wire logic                        hit_way,
    input  wire logic [31:0]                 way_rdata [`DCACHE_NR_WAYS],
    input  wire logic                        victim_way,
    input  wire logic                        victim_dirty,
    output dcache_pkg::index_t               rd_index,
    output logic                             cpu_we,
    output logic                             cpu_way,
    output logic [3:0]                       cpu_wmask,
    output logic [31:0]                      cpu_wdata,
    output logic                             meta_touch,
    output logic                             meta_dirty_set,
    line_xfer_if.ctrl                        xfer
);
    import dcache_pkg::*;
    import dcache_bus_pkg::*;

    localparam int TAG_LSB = `DCACHE_LEN_LINE + `DCACHE_LEN_INDEX;

    state_e state;
    state_e state_nxt;
    tag_t   req_tag;
    logic   lookup_hit;
    logic   lookup_miss;

    // address split
    assign rd_index = mem_addr[TAG_LSB-1:`DCACHE_LEN_LINE];
    assign req_tag = mem_addr[31:TAG_LSB];

    assign lookup_hit = state == LOOKUP && mem_en && hit;
    assign lookup_miss = state == LOOKUP && mem_en && !hit;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, DONE:
                state_nxt = mem_en ? LOOKUP : IDLE; // RAM read goes out now
            LOOKUP: begin
                if (lookup_hit)
                    state_nxt = DONE;
                else if (lookup_miss)
                    state_nxt = victim_dirty ? MISS_WRITEBACK : MISS_REFILL;
                else
                    state_nxt = IDLE;
            end
            MISS_WRITEBACK, MISS_REFILL:
                if (xfer.done) state_nxt = LOOKUP;
            default:
                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    assign stall = mem_en && !lookup_hit;
    assign mem_rdata = way_rdata[hit_way];

    // store on a hit
    assign cpu_we = lookup_hit && mem_write;
    assign cpu_way = hit ? hit_way : victim_way;
    assign cpu_wmask = mem_wmask;
    assign cpu_wdata = mem_wdata;
    assign meta_touch = lookup_hit;
    assign meta_dirty_set = cpu_we;

    // launch the line transfer on a miss
    assign xfer.start = lookup_miss && !xfer.busy;
    assign xfer.op = victim_dirty ? XFER_WRITEBACK : XFER_REFILL;
    assign xfer.index = rd_index;
    assign xfer.tag = req_tag;

endmodule

`default_nettype wire

// ==== verilog/dcache_meta.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_meta (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire dcache_pkg::index_t          index,
    input  wire logic                        touch,
    input  wire logic                        touch_way,
    input  wire logic                        dirty_set,
    input  wire logic                        fill_done,
    input  wire logic                        fill_way,
    input  wire logic                        wb_done,
    output logic [`DCACHE_NR_WAYS-1:0]       valid_bits,
    output logic                             victim_way,
    output logic                             victim_dirty
);
    import dcache_pkg::*;

    localparam int NR_SETS = 1 << `DCACHE_LEN_INDEX;

    meta_t meta [NR_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NR_SETS; s++)
                meta[s] <= '0;
        end else begin
            if (touch) begin
                meta[index].lru <= ~touch_way; // other way goes next
                if (dirty_set)
                    meta[index].dirty[touch_way] <= 1'b1;
            end
            if (fill_done) begin
                meta[index].valid[fill_way] <= 1'b1;
                meta[index].dirty[fill_way] <= 1'b0; // fresh line is clean
            end
            if (wb_done)
                meta[index].dirty[fill_way] <= 1'b0;
        end
    end

    assign valid_bits = meta[index].valid;
    assign victim_way = meta[index].lru;
    assign victim_dirty = meta[index].dirty[meta[index].lru];

endmodule

`default_nettype wire

// ==== verilog/dcache_way_rams.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_way_rams (
    input  wire logic                        clk,
    input  wire dcache_pkg::index_t          rd_index,
    input  wire dcache_pkg::word_off_t       rd_off,
    input  wire dcache_pkg::tag_t            cmp_tag,
    input  wire logic [`DCACHE_NR_WAYS-1:0]  valid_bits,
    output logic                             hit,
    output logic                             hit_way,
    output logic [31:0]                      way_rdata [`DCACHE_NR_WAYS],
    input  wire logic                        cpu_we,
    input  wire logic                        cpu_way,
    input  wire logic [3:0]                  cpu_wmask,
    input  wire logic [31:0]                 cpu_wdata,
    input  wire logic                        fill_we,
    input  wire logic                        fill_way,
    input  wire dcache_pkg::index_t          fill_index,
    input  wire dcache_pkg::word_off_t       fill_off,
    input  wire logic [31:0]                 fill_data,
    input  wire logic                        fill_tag_we,
    input  wire dcache_pkg::tag_t            fill_tag,
    output dcache_pkg::tag_t                 victim_tag
);
    import dcache_pkg::*;

    localparam int NR_SETS = 1 << `DCACHE_LEN_INDEX;
    localparam int NR_WORDS = NR_SETS * `DCACHE_WORDS_PER_LINE;

    tag_t tag_q [`DCACHE_NR_WAYS];
    logic [`DCACHE_NR_WAYS-1:0] match;

    for (genvar w = 0; w < `DCACHE_NR_WAYS; w++) begin : g_way
        logic [31:0] data_mem [NR_WORDS];
        tag_t        tag_mem [NR_SETS];

        always_ff @(posedge clk) begin
            if (fill_we && fill_way == w) begin
                data_mem[{fill_index, fill_off}] <= fill_data; // whole word from memory
            end else if (cpu_we && cpu_way == w) begin
                for (int b = 0; b < 4; b++) begin
                    if (cpu_wmask[b])
                        data_mem[{rd_index, rd_off}][8*b +: 8] <= cpu_wdata[8*b +: 8];
                end
            end
            if (fill_tag_we && fill_way == w)
                tag_mem[fill_index] <= fill_tag;
            way_rdata[w] <= data_mem[{rd_index, rd_off}];
            tag_q[w] <= tag_mem[rd_index];
        end

        assign match[w] = valid_bits[w] && tag_q[w] == cmp_tag;
    end

    assign hit = |match;
    assign hit_way = match[1]; // two ways only
    assign victim_tag = tag_q[fill_way];

endmodule

`default_nettype wire

// ==== verilog/line_xfer_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface line_xfer_if;

    logic                     start; // one-cycle pulse
    dcache_bus_pkg::xfer_op_e op;
    dcache_pkg::index_t       index;
    dcache_pkg::tag_t         tag;   // tag of the requested line
    logic                     busy;
    logic                     done;  // one-cycle pulse

    modport ctrl (
        output start, op, index, tag,
        input  busy, done
    );

    modport mover (
        input  start, op, index, tag,
        output busy, done
    );

endinterface

`default_nettype wire

// ==== verilog/dcache_bus_pkg.sv ====
`default_nettype none

package dcache_bus_pkg;

    // what the line mover does with a line
    typedef enum logic {
        XFER_WRITEBACK,
        XFER_REFILL
    } xfer_op_e;

    // byte address on the memory port
    typedef logic [31:0] mem_addr_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_pkg.sv ====
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_WRITEBACK,
        MISS_REFILL,
        DONE
    } state_e;

    typedef logic [`DCACHE_LEN_INDEX-1:0] index_t;
    typedef logic [31-`DCACHE_LEN_INDEX-`DCACHE_LEN_LINE:0] tag_t;
    typedef logic [`DCACHE_LEN_LINE-3:0] word_off_t;

    typedef struct packed {
        logic [`DCACHE_NR_WAYS-1:0] valid;
        logic [`DCACHE_NR_WAYS-1:0] dirty;
        logic lru; // way to evict next
    } meta_t;

endpackage

`default_nettype wire

// ==== include/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// log2 of bytes per line for 16-byte lines
`define DCACHE_LEN_LINE 4

// log2 of number of sets
`define DCACHE_LEN_INDEX 4

`define DCACHE_NR_WAYS 2

// words per line and the burst length
`define DCACHE_WORDS_PER_LINE 4

`endif
